// ==== design/bpPkg.sv ====
// Sizes and encodings for an RV32I fetch predictor; no compressed opcodes and the table index is fixed to PC[7:2]
package bpPkg;

  ////////////////////////////////////////
  // Widths and table sizes
  ////////////////////////////////////////

  // PC and instruction word width
  localparam int XLEN = 32;

  // Return stack depth, not a power of two
  localparam int RAS_SIZE = 6;
  // Pointer wide enough for RAS_SIZE entries
  localparam int RAS_PTR_BITS = 3;

  // Bimodal direction table
  localparam int DIR_ENTRIES = 64;
  // Index comes from PC[7:2]
  localparam int DIR_INDEX_BITS = 6;

  ////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////

  // Major opcodes seen by the predecoder
  // OP_OTHER is an unused encoding that stands for everything else
  typedef enum logic [6:0] {
    OP_BRANCH = 7'b1100011,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_OTHER  = 7'b0000000
  } opcode_t;

  // Control flow class carried down the pipe
  // Call is jal/jalr with rd in {x1, x5}
  // Return is jalr with rd x0 and rs1 in {x1, x5}
  typedef enum logic [2:0] {
    CLASS_OTHER  = 3'd0,
    CLASS_BRANCH = 3'd1,
    CLASS_JAL    = 3'd2,
    CLASS_CALL   = 3'd3,
    CLASS_RETURN = 3'd4
  } instrClass_t;

  // 2-bit saturating direction counter
  // Upper bit set means predict taken
  typedef enum logic [1:0] {
    STRONG_NT = 2'b00,
    WEAK_NT   = 2'b01,
    WEAK_T    = 2'b10,
    STRONG_T  = 2'b11
  } counter_t;

endpackage

// ==== design/fetchPredecode.sv ====
// Exact RV32I predecode of 32-bit words only; a flush clears a stage only when that stage is not stalled
`timescale 1ns/100ps

module fetchPredecode (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  StallD,
  input  logic                  StallE,
  input  logic                  FlushD,
  input  logic                  FlushE,
  input  logic [bpPkg::XLEN-1:0] PCF,
  input  logic [bpPkg::XLEN-1:0] InstrF,
  output logic                  ReturnF,
  output logic                  BranchF,
  output logic                  JalF,
  output logic [bpPkg::XLEN-1:0] ImmF,
  output logic                  ReturnD,
  output logic                  ReturnE,
  output logic                  CallE,
  output logic                  BranchE,
  output logic [bpPkg::XLEN-1:0] PCE,
  output logic [bpPkg::XLEN-1:0] PCLinkE
);

  bpPkg::opcode_t     opF;
  bpPkg::instrClass_t classF;
  bpPkg::instrClass_t classD;
  bpPkg::instrClass_t classE;
  logic [4:0]         rdF;
  logic [4:0]         rs1F;
  logic               linkRdF;
  logic               linkRs1F;
  logic [bpPkg::XLEN-1:0] immBranchF;
  logic [bpPkg::XLEN-1:0] immJalF;
  logic [bpPkg::XLEN-1:0] pcD;
  logic [bpPkg::XLEN-1:0] linkD;

  ////////////////////////////////////////
  // F stage predecode
  ////////////////////////////////////////

  // Register fields
  assign rdF  = InstrF[11:7];
  assign rs1F = InstrF[19:15];

  // x1 and x5 are the link registers
  assign linkRdF  = (rdF == 5'd1) || (rdF == 5'd5);
  assign linkRs1F = (rs1F == 5'd1) || (rs1F == 5'd5);

  // Opcode map, illegal funct3 codes fall to OP_OTHER
  always_comb begin
    case (InstrF[6:0])
      bpPkg::OP_BRANCH: opF = (InstrF[14:13] == 2'b01) ? bpPkg::OP_OTHER : bpPkg::OP_BRANCH;
      bpPkg::OP_JAL:    opF = bpPkg::OP_JAL;
      bpPkg::OP_JALR:   opF = (InstrF[14:12] == 3'b000) ? bpPkg::OP_JALR : bpPkg::OP_OTHER;
      default:          opF = bpPkg::OP_OTHER;
    endcase
  end

  // Class from opcode plus rd/rs1
  always_comb begin
    classF = bpPkg::CLASS_OTHER;
    case (opF)
      bpPkg::OP_BRANCH: classF = bpPkg::CLASS_BRANCH;
      bpPkg::OP_JAL:    classF = linkRdF ? bpPkg::CLASS_CALL : bpPkg::CLASS_JAL;
      bpPkg::OP_JALR: begin
        if (linkRdF) begin
          classF = bpPkg::CLASS_CALL;
        end else if ((rdF == 5'd0) && linkRs1F) begin
          classF = bpPkg::CLASS_RETURN;
        end
      end
      default:          classF = bpPkg::CLASS_OTHER;
    endcase
  end

  // B-type and J-type immediates, sign extended
  assign immBranchF = {{(bpPkg::XLEN-12){InstrF[31]}}, InstrF[7], InstrF[30:25],
                       InstrF[11:8], 1'b0};
  assign immJalF    = {{(bpPkg::XLEN-20){InstrF[31]}}, InstrF[19:12], InstrF[20],
                       InstrF[30:21], 1'b0};

  // Jal target also covers jal calls
  assign JalF    = (opF == bpPkg::OP_JAL);
  assign BranchF = (classF == bpPkg::CLASS_BRANCH);
  assign ReturnF = (classF == bpPkg::CLASS_RETURN);
  assign ImmF    = JalF ? immJalF : immBranchF;

  ////////////////////////////////////////
  // D and E stage registers
  ////////////////////////////////////////

  // D class, flush kills the word leaving F
  always_ff @(posedge clk) begin
    if (reset) begin
      classD <= bpPkg::CLASS_OTHER;
    end else if (!StallD) begin
      classD <= FlushD ? bpPkg::CLASS_OTHER : classF;
    end
  end

  // D payload, link address formed on entry to D
  always_ff @(posedge clk) begin
    if (!StallD) begin
      pcD   <= PCF;
      linkD <= PCF + bpPkg::XLEN'(4);
    end
  end

  // E class
  always_ff @(posedge clk) begin
    if (reset) begin
      classE <= bpPkg::CLASS_OTHER;
    end else if (!StallE) begin
      classE <= FlushE ? bpPkg::CLASS_OTHER : classD;
    end
  end

  // E payload
  always_ff @(posedge clk) begin
    if (!StallE) begin
      PCE     <= pcD;
      PCLinkE <= linkD;
    end
  end

  assign ReturnD = (classD == bpPkg::CLASS_RETURN);
  assign ReturnE = (classE == bpPkg::CLASS_RETURN);
  assign CallE   = (classE == bpPkg::CLASS_CALL);
  assign BranchE = (classE == bpPkg::CLASS_BRANCH);

  // An E stall must hold D too or the word waiting in D is overwritten
  assert property (@(posedge clk) disable iff (reset) StallE |-> StallD);

endmodule

// ==== design/returnStack.sv ====
// Six-entry circular return stack; overflow silently overwrites the oldest entry, no class-mismatch repair
`timescale 1ns/100ps

module returnStack (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  StallD,
  input  logic                  StallE,
  input  logic                  StallM,
  input  logic                  FlushD,
  input  logic                  FlushE,
  input  logic                  FlushM,
  input  logic                  ReturnF,
  input  logic                  ReturnD,
  input  logic                  ReturnE,
  input  logic                  CallE,
  input  logic [bpPkg::XLEN-1:0] PCLinkE,
  output logic [bpPkg::XLEN-1:0] RASPCF
);

  logic [bpPkg::XLEN-1:0]         stack [bpPkg::RAS_SIZE];
  logic [bpPkg::RAS_PTR_BITS-1:0] ptr;
  logic [bpPkg::RAS_PTR_BITS-1:0] ptrUp;
  logic [bpPkg::RAS_PTR_BITS-1:0] ptrDown;
  logic                           popF;
  logic                           pushE;
  logic                           repair;
  logic                           incPtr;
  logic                           decPtr;

  ////////////////////////////////////////
  // Stack requests
  ////////////////////////////////////////

  // Return leaves F
  assign popF  = ReturnF && !StallD && !FlushD;
  // Call leaves E
  assign pushE = CallE && !StallM && !FlushM;

  // Popped return killed in D or E, give its entry back
  assign repair = (ReturnD && FlushE && !StallE) || (ReturnE && FlushM);

  // Increment beats a coincident pop
  assign incPtr = pushE || repair;
  assign decPtr = popF && !incPtr;

  ////////////////////////////////////////
  // Pointer with wrap at RAS_SIZE
  ////////////////////////////////////////

  // Top entry wraps to 0
  assign ptrUp = (ptr == bpPkg::RAS_PTR_BITS'(bpPkg::RAS_SIZE - 1)) ?
                 '0 : ptr + bpPkg::RAS_PTR_BITS'(1);

  // Entry 0 wraps to the top
  assign ptrDown = (ptr == '0) ?
                   bpPkg::RAS_PTR_BITS'(bpPkg::RAS_SIZE - 1) : ptr - bpPkg::RAS_PTR_BITS'(1);

  always_ff @(posedge clk) begin
    if (reset) begin
      ptr <= '0;
    end else if (incPtr) begin
      ptr <= ptrUp;
    end else if (decPtr) begin
      ptr <= ptrDown;
    end
  end

  // Link storage, push lands one above the pointer
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < bpPkg::RAS_SIZE; i++) begin
        stack[i] <= '0;
      end
    end else if (pushE) begin
      stack[ptrUp] <= PCLinkE;
    end
  end

  // Predicted return target
  assign RASPCF = stack[ptr];

  // Stale pointer codes 6 and 7 never reached
  assert property (@(posedge clk) disable iff (reset) ptr < bpPkg::RAS_SIZE);

endmodule

// ==== design/directionTable.sv ====
// Bimodal predictor with no tags; branches that share PC[7:2] alias onto one counter
`timescale 1ns/100ps

module directionTable (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  StallM,
  input  logic                  FlushM,
  input  logic                  BranchE,
  input  logic                  TakenE,
  input  logic [bpPkg::XLEN-1:0] PCF,
  input  logic [bpPkg::XLEN-1:0] PCE,
  output logic                  PredTakenF
);

  bpPkg::counter_t                  counters [bpPkg::DIR_ENTRIES];
  bpPkg::counter_t                  readCount;
  bpPkg::counter_t                  trainCount;
  bpPkg::counter_t                  nextCount;
  logic [bpPkg::DIR_INDEX_BITS-1:0] readIdx;
  logic [bpPkg::DIR_INDEX_BITS-1:0] trainIdx;
  logic                             trainE;

  ////////////////////////////////////////
  // Fetch side lookup
  ////////////////////////////////////////

  // Word index, bits 1:0 always zero
  assign readIdx   = PCF[bpPkg::DIR_INDEX_BITS+1:2];
  assign readCount = counters[readIdx];

  // Taken for either taken state
  assign PredTakenF = (readCount == bpPkg::WEAK_T) || (readCount == bpPkg::STRONG_T);

  ////////////////////////////////////////
  // Training from E
  ////////////////////////////////////////

  // Resolved branch leaving E
  assign trainE     = BranchE && !StallM && !FlushM;
  assign trainIdx   = PCE[bpPkg::DIR_INDEX_BITS+1:2];
  assign trainCount = counters[trainIdx];

  // One step toward the outcome, saturating at both ends
  always_comb begin
    case (trainCount)
      bpPkg::STRONG_NT: nextCount = TakenE ? bpPkg::WEAK_NT  : bpPkg::STRONG_NT;
      bpPkg::WEAK_NT:   nextCount = TakenE ? bpPkg::WEAK_T   : bpPkg::STRONG_NT;
      bpPkg::WEAK_T:    nextCount = TakenE ? bpPkg::STRONG_T : bpPkg::WEAK_NT;
      bpPkg::STRONG_T:  nextCount = TakenE ? bpPkg::STRONG_T : bpPkg::WEAK_T;
      default:          nextCount = bpPkg::WEAK_NT;
    endcase
  end

  // Counter array, all weak not-taken out of reset
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < bpPkg::DIR_ENTRIES; i++) begin
        counters[i] <= bpPkg::WEAK_NT;
      end
    end else if (trainE) begin
      counters[trainIdx] <= nextCount;
    end
  end

  // Outcome from the E stage must be resolved by the time it trains
  assert property (@(posedge clk) disable iff (reset) trainE |-> !$isunknown(TakenE));

endmodule

// ==== design/nextPcSelect.sv ====
// Fetch-cycle next PC choice; jalr other than returns falls through to PC+4
`timescale 1ns/100ps

module nextPcSelect (
  input  logic                  ReturnF,
  input  logic                  BranchF,
  input  logic                  JalF,
  input  logic                  PredTakenF,
  input  logic [bpPkg::XLEN-1:0] PCF,
  input  logic [bpPkg::XLEN-1:0] ImmF,
  input  logic [bpPkg::XLEN-1:0] RASPCF,
  output logic [bpPkg::XLEN-1:0] PredPCF,
  output logic                  PredRedirectF
);

  logic [bpPkg::XLEN-1:0] pcPlus4F;
  logic [bpPkg::XLEN-1:0] pcTargetF;
  logic                   takeTargetF;

  ////////////////////////////////////////
  // Candidate addresses
  ////////////////////////////////////////

  // Sequential fetch, 32-bit words only
  assign pcPlus4F = PCF + bpPkg::XLEN'(4);

  // PC-relative target for jal and branches
  assign pcTargetF = PCF + ImmF;

  ////////////////////////////////////////
  // Selection
  ////////////////////////////////////////

  // Jal always, branch only when the counter says taken
  assign takeTargetF = JalF || (BranchF && PredTakenF);

  // Return has priority, classes are exclusive anyway
  always_comb begin
    if (ReturnF) begin
      PredPCF = RASPCF;
    end else if (takeTargetF) begin
      PredPCF = pcTargetF;
    end else begin
      PredPCF = pcPlus4F;
    end
  end

  // Any choice other than the sequential PC
  assign PredRedirectF = ReturnF || takeTargetF;

endmodule

// ==== design/branchPredictor.sv ====
// Fetch-stage predictor top; the pipeline must hold F whenever D is stalled so a held return is refetched
`timescale 1ns/100ps

module branchPredictor (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  StallF,
  input  logic                  StallD,
  input  logic                  StallE,
  input  logic                  StallM,
  input  logic                  FlushD,
  input  logic                  FlushE,
  input  logic                  FlushM,
  input  logic [bpPkg::XLEN-1:0] PCF,
  input  logic [bpPkg::XLEN-1:0] InstrF,
  input  logic                  TakenE,
  output logic [bpPkg::XLEN-1:0] PredPCF,
  output logic                  PredRedirectF
);

  // F stage predecode results
  logic                   ReturnF;
  logic                   BranchF;
  logic                   JalF;
  logic [bpPkg::XLEN-1:0] ImmF;
  // Pipelined class and addresses
  logic                   ReturnD;
  logic                   ReturnE;
  logic                   CallE;
  logic                   BranchE;
  logic [bpPkg::XLEN-1:0] PCE;
  logic [bpPkg::XLEN-1:0] PCLinkE;
  // Predictor state reads
  logic [bpPkg::XLEN-1:0] RASPCF;
  logic                   PredTakenF;

  ////////////////////////////////////////
  // Input side
  ////////////////////////////////////////

  fetchPredecode predecode_i (
    .clk(clk), .reset(reset),
    .StallD(StallD), .StallE(StallE), .FlushD(FlushD), .FlushE(FlushE),
    .PCF(PCF), .InstrF(InstrF),
    .ReturnF(ReturnF), .BranchF(BranchF), .JalF(JalF), .ImmF(ImmF),
    .ReturnD(ReturnD), .ReturnE(ReturnE), .CallE(CallE), .BranchE(BranchE),
    .PCE(PCE), .PCLinkE(PCLinkE)
  );

  ////////////////////////////////////////
  // Predictor state
  ////////////////////////////////////////

  returnStack ras_i (
    .clk(clk), .reset(reset),
    .StallD(StallD), .StallE(StallE), .StallM(StallM),
    .FlushD(FlushD), .FlushE(FlushE), .FlushM(FlushM),
    .ReturnF(ReturnF), .ReturnD(ReturnD), .ReturnE(ReturnE), .CallE(CallE),
    .PCLinkE(PCLinkE), .RASPCF(RASPCF)
  );

  directionTable dir_i (
    .clk(clk), .reset(reset),
    .StallM(StallM), .FlushM(FlushM),
    .BranchE(BranchE), .TakenE(TakenE),
    .PCF(PCF), .PCE(PCE),
    .PredTakenF(PredTakenF)
  );

  ////////////////////////////////////////
  // Output side
  ////////////////////////////////////////

  nextPcSelect select_i (
    .ReturnF(ReturnF), .BranchF(BranchF), .JalF(JalF), .PredTakenF(PredTakenF),
    .PCF(PCF), .ImmF(ImmF), .RASPCF(RASPCF),
    .PredPCF(PredPCF), .PredRedirectF(PredRedirectF)
  );

  // A D stall must freeze F too, or an unpopped return would be lost
  assert property (@(posedge clk) disable iff (reset) StallD |-> StallF);

endmodule

// ==== tests/branchPredictorTb.sv ====
// Table-driven testbench; rows run back to back, so RAS and counter state carry from row to row
`timescale 1ns/100ps

module branchPredictorTb;

  localparam int MAX_ROWS      = 64;
  localparam int RESET_TIMEOUT = 40;

  logic        clk;
  logic        reset;
  logic        StallF;
  logic        StallD;
  logic        StallE;
  logic        StallM;
  logic        FlushD;
  logic        FlushE;
  logic        FlushM;
  logic [31:0] PCF;
  logic [31:0] InstrF;
  logic        TakenE;
  logic [31:0] PredPCF;
  logic        PredRedirectF;

  // Stimulus and expected values, one entry per row
  string       rowName     [MAX_ROWS];
  logic [31:0] rowPc       [MAX_ROWS];
  logic [31:0] rowInstr    [MAX_ROWS];
  logic [3:0]  rowStall    [MAX_ROWS];
  logic [2:0]  rowFlush    [MAX_ROWS];
  logic        rowTaken    [MAX_ROWS];
  logic [31:0] rowExpPc    [MAX_ROWS];
  logic        rowExpRedir [MAX_ROWS];
  bit          rowFiller   [MAX_ROWS];
  int          rowCount;
  int          passCount;
  int          failCount;
  integer      seed;

  branchPredictor dut_i (
    .clk(clk), .reset(reset),
    .StallF(StallF), .StallD(StallD), .StallE(StallE), .StallM(StallM),
    .FlushD(FlushD), .FlushE(FlushE), .FlushM(FlushM),
    .PCF(PCF), .InstrF(InstrF), .TakenE(TakenE),
    .PredPCF(PredPCF), .PredRedirectF(PredRedirectF)
  );

  ////////////////////////////////////////
  // Clock and reset
  ////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // All inputs quiet while reset is held
  initial begin
    reset  = 1'b1;
    StallF = 1'b0;
    StallD = 1'b0;
    StallE = 1'b0;
    StallM = 1'b0;
    FlushD = 1'b0;
    FlushE = 1'b0;
    FlushM = 1'b0;
    PCF    = '0;
    InstrF = '0;
    TakenE = 1'b0;
    repeat (16) @(posedge clk);
    reset <= 1'b0;
  end

  ////////////////////////////////////////
  // RV32I encoders
  ////////////////////////////////////////

  // J-type, imm[0] dropped
  function automatic logic [31:0] jalInstr(input logic [4:0] rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  // I-type with zero offset
  function automatic logic [31:0] jalrInstr(input logic [4:0] rd, input logic [4:0] rs1);
    return {12'd0, rs1, 3'b000, rd, 7'b1100111};
  endfunction

  // beq x1, x2
  function automatic logic [31:0] beqInstr(input logic [12:0] imm);
    return {imm[12], imm[10:5], 5'd2, 5'd1, 3'b000, imm[4:1], imm[11], 7'b1100011};
  endfunction

  ////////////////////////////////////////
  // Table construction
  ////////////////////////////////////////

  task automatic storeRow(input string name, input logic [31:0] pc, input logic [31:0] instr,
                          input logic [3:0] stall, input logic [2:0] flush, input logic taken,
                          input logic [31:0] expPc, input logic expRedir, input bit filler);
    rowName[rowCount]     = name;
    rowPc[rowCount]       = pc;
    rowInstr[rowCount]    = instr;
    rowStall[rowCount]    = stall;
    rowFlush[rowCount]    = flush;
    rowTaken[rowCount]    = taken;
    rowExpPc[rowCount]    = expPc;
    rowExpRedir[rowCount] = expRedir;
    rowFiller[rowCount]   = filler;
    rowCount++;
  endtask

  // Control flow row, stall bits are {F, D, E, M}
  task automatic addCtrl(input string name, input logic [31:0] pc, input logic [31:0] instr,
                         input logic [3:0] stall, input logic [31:0] expPc, input logic expRedir);
    storeRow(name, pc, instr, stall, 3'b000, 1'b0, expPc, expRedir, 1'b0);
  endtask

  // Non-control word, always falls through to PC+4; flush bits are {D, E, M}
  task automatic addFiller(input string name, input logic [31:0] pc, input logic [2:0] flush,
                           input logic taken);
    storeRow(name, pc, 32'h0, 4'b0000, flush, taken, pc + 32'd4, 1'b0, 1'b1);
  endtask

  task automatic buildTable();
    logic [31:0] ret;
    logic [31:0] pc;
    ret = jalrInstr(5'd0, 5'd1);
    rowCount = 0;
    // Empty stack reads zero, pointer wraps 0 to 5
    addCtrl("resetReturn", 32'h1000, ret, 4'b0000, 32'h0, 1'b1);
    addFiller("resetFallThrough", 32'h1004, 3'b000, 1'b0);
    addCtrl("jalNoLink", 32'h1008, jalInstr(5'd0, 21'h40), 4'b0000, 32'h1048, 1'b1);
    // Call pushed as it leaves E two rows later
    addCtrl("callJal", 32'h2000, jalInstr(5'd1, 21'h100), 4'b0000, 32'h2100, 1'b1);
    addFiller("callInD", 32'h2100, 3'b000, 1'b0);
    addFiller("callInE", 32'h2104, 3'b000, 1'b0);
    addCtrl("returnAfterCall", 32'h2108, ret, 4'b0000, 32'h2004, 1'b1);
    // Nested calls, jalr call has no predicted target
    addCtrl("nestCall1", 32'h3000, jalInstr(5'd1, 21'h100), 4'b0000, 32'h3100, 1'b1);
    addCtrl("nestCall2", 32'h3100, jalInstr(5'd1, 21'h100), 4'b0000, 32'h3200, 1'b1);
    addCtrl("nestCall3Jalr", 32'h3200, jalrInstr(5'd5, 5'd10), 4'b0000, 32'h3204, 1'b0);
    addFiller("nestFill1", 32'h3204, 3'b000, 1'b0);
    addFiller("nestFill2", 32'h3208, 3'b000, 1'b0);
    addCtrl("nestRet3", 32'h320c, ret, 4'b0000, 32'h3204, 1'b1);
    addCtrl("nestRet2X5", 32'h3210, jalrInstr(5'd0, 5'd5), 4'b0000, 32'h3104, 1'b1);
    addCtrl("nestRet1", 32'h3214, ret, 4'b0000, 32'h3004, 1'b1);
    // Seven calls into six entries, the last overwrites the first
    for (int k = 0; k < 7; k++) begin
      pc = 32'h4000 + k * 32'h100;
      addCtrl($sformatf("wrapCall%0d", k), pc, jalInstr(5'd1, 21'h100), 4'b0000,
              pc + 32'h100, 1'b1);
    end
    addFiller("wrapFill1", 32'h4700, 3'b000, 1'b0);
    addFiller("wrapFill2", 32'h4704, 3'b000, 1'b0);
    // Newest first, seventh pop lands back on the overwritten entry
    for (int k = 0; k < 7; k++) begin
      addCtrl($sformatf("wrapRet%0d", k), 32'h4708 + k * 32'd4, ret, 4'b0000,
              (k == 6) ? 32'h4604 : 32'h4604 - k * 32'h100, 1'b1);
    end
    // Return flushed in D, then a return flushed in E
    addCtrl("repairPop", 32'h5000, ret, 4'b0000, 32'h4504, 1'b1);
    addFiller("repairFlushD", 32'h5004, 3'b110, 1'b0);
    addCtrl("repairRetry", 32'h5000, ret, 4'b0000, 32'h4504, 1'b1);
    addFiller("repairTarget", 32'h4504, 3'b000, 1'b0);
    addFiller("repairFlushE", 32'h4508, 3'b111, 1'b0);
    addCtrl("repairRetryE", 32'h6000, ret, 4'b0000, 32'h4504, 1'b1);
    // F and D stalled, no pop
    addFiller("stallTarget", 32'h4504, 3'b000, 1'b0);
    addCtrl("stallReturn", 32'h4508, ret, 4'b1100, 32'h4404, 1'b1);
    addCtrl("stallRelease", 32'h4508, ret, 4'b0000, 32'h4404, 1'b1);
    // Branch at index 4, outcome given on the row where it sits in E
    addCtrl("branchCold", 32'h7010, beqInstr(13'h40), 4'b0000, 32'h7014, 1'b0);
    addFiller("branchFill1", 32'h7014, 3'b000, 1'b0);
    addFiller("branchTrainT1", 32'h7018, 3'b000, 1'b1);
    addCtrl("branchWeakTaken", 32'h7010, beqInstr(13'h40), 4'b0000, 32'h7050, 1'b1);
    addFiller("branchFill2", 32'h7050, 3'b000, 1'b0);
    addFiller("branchTrainT2", 32'h7054, 3'b000, 1'b1);
    addCtrl("branchStrongTaken", 32'h7010, beqInstr(13'h40), 4'b0000, 32'h7050, 1'b1);
    addFiller("branchFill3", 32'h7014, 3'b000, 1'b0);
    addFiller("branchTrainNT1", 32'h7018, 3'b000, 1'b0);
    // One not-taken only drops to weak taken
    addCtrl("branchHysteresis", 32'h7010, beqInstr(13'h40), 4'b0000, 32'h7050, 1'b1);
    addFiller("branchFill4", 32'h7014, 3'b000, 1'b0);
    addFiller("branchTrainNT2", 32'h7018, 3'b000, 1'b0);
    addCtrl("branchBackNT", 32'h7010, beqInstr(13'h40), 4'b0000, 32'h7014, 1'b0);
  endtask

  ////////////////////////////////////////
  // Drive and check
  ////////////////////////////////////////

  task automatic waitResetRelease(output bit released);
    int cycles;
    cycles = 0;
    while (reset !== 1'b0 && cycles < RESET_TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    released = (reset === 1'b0);
  endtask

  // Called right after a rising edge
  task automatic applyRow(input int r);
    logic [31:0] instr;
    instr = rowInstr[r];
    if (rowFiller[r]) begin
      // Random word forced onto OP-IMM
      instr = $random(seed);
      instr[6:0] = 7'b0010011;
    end
    PCF    <= rowPc[r];
    InstrF <= instr;
    {StallF, StallD, StallE, StallM} <= rowStall[r];
    {FlushD, FlushE, FlushM} <= rowFlush[r];
    TakenE <= rowTaken[r];
  endtask

  task automatic checkRow(input int r);
    if (PredPCF !== rowExpPc[r] || PredRedirectF !== rowExpRedir[r]) begin
      failCount++;
      $display("[FAIL] %s expected PredPCF %h redirect %b, actual PredPCF %h redirect %b",
               rowName[r], rowExpPc[r], rowExpRedir[r], PredPCF, PredRedirectF);
    end else begin
      passCount++;
      $display("[PASS] %s PredPCF %h redirect %b", rowName[r], PredPCF, PredRedirectF);
    end
  endtask

  initial begin
    bit released;
    seed      = 32'h41c9;
    passCount = 0;
    failCount = 0;
    buildTable();
    waitResetRelease(released);
    if (!released) begin
      $display("Reset still high after %0d clock cycles", RESET_TIMEOUT);
      $display("Simulation FAILED");
    end else begin
      for (int r = 0; r < rowCount; r++) begin
        applyRow(r);
        // Outputs settle well before the falling edge
        @(negedge clk);
        checkRow(r);
        @(posedge clk);
      end
      $display("Tests %0d, passed %0d, failed %0d", rowCount, passCount, failCount);
      if (failCount == 0) begin
        $display("Simulation PASSED");
      end else begin
        $display("Simulation FAILED");
      end
    end
    $finish;
  end

endmodule

// ==== build.f ====
design/bpPkg.sv
design/fetchPredecode.sv
design/returnStack.sv
design/directionTable.sv
design/nextPcSelect.sv
design/branchPredictor.sv
tests/branchPredictorTb.sv

// ==== Bender.yml ====
package:
  name: branch_predictor

sources:
  # Package first, then leaf modules, then the top level
  - design/bpPkg.sv
  - design/fetchPredecode.sv
  - design/returnStack.sv
  - design/directionTable.sv
  - design/nextPcSelect.sv
  - design/branchPredictor.sv

  - target: test
    files:
      - tests/branchPredictorTb.sv
